//--- filelist.f
source/u1e_pkg.sv
source/wb_decoder.sv
source/misc_regs.sv
source/settings_bus_16le.sv
source/vita_time.sv
source/u1e_core.sv
test/tb_clock_gen.sv
test/u1e_core_properties.sv
test/u1e_core_tb.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/1ps --top-module u1e_core_tb \
   -f filelist.f -o u1e_core_sim &&
./obj_dir/u1e_core_sim ||
{ echo "Simulation run did not pass"; exit 1; }

//--- source/misc_regs.sv
`timescale 1ns/1ps
`default_nettype none

module misc_regs
  (
   input  wire                 wb_clk,
   input  wire                 wb_rst,
   input  u1e_pkg::wb_req_t    req_i,
   output u1e_pkg::wb_rsp_t    rsp_o,

   input  wire [7:0]           dip_sw_i,
   input  wire [2:0]           debug_pb_i,
   input  wire                 cgen_st_status_i,
   input  wire                 cgen_st_ld_i,
   input  wire                 cgen_st_refmon_i,

   output logic [2:0]          debug_led_o,
   output logic                cgen_sync_b_o,
   output logic                cgen_ref_sel_o,
   output logic                rx_overrun_o,
   output logic                tx_underrun_o
   );

   logic [u1e_pkg::DW-1:0] reg_leds;
   logic [u1e_pkg::DW-1:0] reg_cgen_ctrl;
   logic [u1e_pkg::DW-1:0] reg_test;
   logic [6:0]             offs;
   logic                   wr_en;

   assign offs  = req_i.adr[6:0];
   assign wr_en = req_i.cyc & req_i.stb & req_i.we;

   ////////////////////
   // Writable registers
   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
      begin
         reg_leds      <= '0;
         reg_cgen_ctrl <= {14'd0, u1e_pkg::CGEN_CTRL_RST};
         reg_test      <= '0;
      end
      else if (wr_en)
      begin
         case (offs)
            u1e_pkg::MR_LEDS      : reg_leds      <= req_i.dat;
            u1e_pkg::MR_CGEN_CTRL : reg_cgen_ctrl <= req_i.dat;
            u1e_pkg::MR_TEST      : reg_test      <= req_i.dat;
            default               : ;    // Read-only or unknown
         endcase
      end
   end

   // Board wires LED 0 and 1 crossed
   assign debug_led_o    = {reg_leds[2], reg_leds[0], reg_leds[1]};
   assign cgen_sync_b_o  = reg_cgen_ctrl[1];
   assign cgen_ref_sel_o = reg_cgen_ctrl[0];
   assign rx_overrun_o   = reg_test[1];
   assign tx_underrun_o  = reg_test[0];

   ////////////////////
   // Readback
   always_comb
   begin
      case (offs)
         u1e_pkg::MR_LEDS      : rsp_o.dat = reg_leds;
         u1e_pkg::MR_SWITCHES  : rsp_o.dat = {5'd0, debug_pb_i, dip_sw_i};
         u1e_pkg::MR_CGEN_CTRL : rsp_o.dat = reg_cgen_ctrl;
         u1e_pkg::MR_CGEN_ST   : rsp_o.dat = {13'd0, cgen_st_status_i, cgen_st_ld_i,
                                              cgen_st_refmon_i};
         u1e_pkg::MR_TEST      : rsp_o.dat = reg_test;
         default               : rsp_o.dat = u1e_pkg::MISC_DEFAULT_RD;
      endcase
   end

   assign rsp_o.ack = req_i.cyc & req_i.stb;   // Zero wait states

endmodule

`default_nettype wire

//--- source/settings_bus_16le.sv
`timescale 1ns/1ps
`default_nettype none

module settings_bus_16le
  (
   input  wire                 wb_clk,
   input  wire                 wb_rst,
   input  u1e_pkg::wb_req_t    req_i,
   output u1e_pkg::wb_rsp_t    rsp_o,
   output u1e_pkg::set_bus_t   set_o
   );

   logic                          wr_en;
   logic                          wr_hi;
   logic [u1e_pkg::DW-1:0]        low_half;    // Held until the high half arrives
   logic                          set_stb;
   logic [u1e_pkg::SET_AW-1:0]    set_addr;
   logic [u1e_pkg::SET_DW-1:0]    set_data;

   assign wr_en = req_i.cyc & req_i.stb & req_i.we;
   assign wr_hi = req_i.adr[1];

   ////////////////////
   // Half-word capture
   always_ff @(posedge wb_clk)
   begin
      if (wr_en && !wr_hi)
      begin
         low_half <= req_i.dat;
      end
   end

   always_ff @(posedge wb_clk)
   begin
      if (wr_en && wr_hi)
      begin
         set_data <= {req_i.dat, low_half};
         set_addr <= {3'd0, req_i.adr[6:2]};   // Word index of the 32-bit register
      end
   end

   // One-cycle strobe after the high half
   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
      begin
         set_stb <= 1'b0;
      end
      else
      begin
         set_stb <= wr_en & wr_hi;
      end
   end

   assign set_o.stb  = set_stb;
   assign set_o.addr = set_addr;
   assign set_o.data = set_data;

   // Write-only slave
   assign rsp_o.dat = '0;
   assign rsp_o.ack = req_i.cyc & req_i.stb;

endmodule

`default_nettype wire

//--- source/u1e_core.sv
`timescale 1ns/1ps
`default_nettype none

module u1e_core
  (
   input  wire                 wb_clk,
   input  wire                 wb_rst,

   input  u1e_pkg::wb_req_t    m_req_i,
   output u1e_pkg::wb_rsp_t    m_rsp_o,

   // Board pins on the misc bank
   input  wire [7:0]           dip_sw_i,
   input  wire [2:0]           debug_pb_i,
   input  wire                 cgen_st_status_i,
   input  wire                 cgen_st_ld_i,
   input  wire                 cgen_st_refmon_i,
   output wire [2:0]           debug_led_o,
   output wire                 cgen_sync_b_o,
   output wire                 cgen_ref_sel_o,
   output wire                 rx_overrun_o,
   output wire                 tx_underrun_o,

   input  wire                 pps_i,
   output wire [63:0]          vita_time_o,
   output wire                 pps_int_o
   );

   u1e_pkg::wb_req_t  misc_req;
   u1e_pkg::wb_rsp_t  misc_rsp;
   u1e_pkg::wb_req_t  set_req;
   u1e_pkg::wb_rsp_t  set_rsp;
   u1e_pkg::set_bus_t set_bus;

   ////////////////////
   // Intercon
   wb_decoder u_decoder
     (.wb_clk(wb_clk),
      .m_req_i(m_req_i), .m_rsp_o(m_rsp_o),
      .misc_req_o(misc_req), .misc_rsp_i(misc_rsp),
      .set_req_o(set_req), .set_rsp_i(set_rsp));

   // Slave 0
   misc_regs u_misc_regs
     (.wb_clk(wb_clk), .wb_rst(wb_rst),
      .req_i(misc_req), .rsp_o(misc_rsp),
      .dip_sw_i(dip_sw_i), .debug_pb_i(debug_pb_i),
      .cgen_st_status_i(cgen_st_status_i),
      .cgen_st_ld_i(cgen_st_ld_i),
      .cgen_st_refmon_i(cgen_st_refmon_i),
      .debug_led_o(debug_led_o),
      .cgen_sync_b_o(cgen_sync_b_o), .cgen_ref_sel_o(cgen_ref_sel_o),
      .rx_overrun_o(rx_overrun_o), .tx_underrun_o(tx_underrun_o));

   // Slave 5
   settings_bus_16le u_settings_bus
     (.wb_clk(wb_clk), .wb_rst(wb_rst),
      .req_i(set_req), .rsp_o(set_rsp),
      .set_o(set_bus));

   ////////////////////
   // VITA time
   vita_time u_vita_time
     (.wb_clk(wb_clk), .wb_rst(wb_rst),
      .set_i(set_bus),
      .pps_i(pps_i),
      .vita_time_o(vita_time_o),
      .pps_int_o(pps_int_o));

endmodule

`default_nettype wire

//--- source/u1e_pkg.sv
`default_nettype none

package u1e_pkg;

   ////////////////////
   // Wishbone geometry
   localparam int DW       = 16;
   localparam int AW       = 11;
   localparam int SW       = 2;
   localparam int DECODE_W = 4;     // adr[10:7] picks the slave

   localparam logic [DECODE_W-1:0] SLOT_MISC     = 4'd0;
   localparam logic [DECODE_W-1:0] SLOT_SETTINGS = 4'd5;

   ////////////////////
   // Settings bus and timer
   localparam int SET_AW = 8;
   localparam int SET_DW = 32;

   localparam logic [31:0]       TICKS_PER_SEC = 32'd100;   // Short second for simulation
   localparam logic [SET_AW-1:0] SR_TIME_BASE  = 8'd0;

   // Misc register offsets in adr[6:0]
   typedef enum logic [6:0] {
      MR_LEDS      = 7'd0,
      MR_SWITCHES  = 7'd2,
      MR_CGEN_CTRL = 7'd4,
      MR_CGEN_ST   = 7'd6,
      MR_TEST      = 7'd8
   } misc_reg_e;

   localparam logic [DW-1:0] MISC_DEFAULT_RD = 16'hBEEF;
   localparam logic [1:0]    CGEN_CTRL_RST   = 2'b11;   // Sync deasserted, ref select high

   // Timer registers, relative to SR_TIME_BASE
   typedef enum logic [SET_AW-1:0] {
      SR_TIME_HI   = 8'd0,     // Seconds
      SR_TIME_LO   = 8'd1,     // Ticks, arms the load
      SR_TIME_CTRL = 8'd2      // Bit 0 selects load on PPS
   } time_reg_e;

   ////////////////////
   // Bus bundles
   typedef struct packed {
      logic [AW-1:0] adr;
      logic [DW-1:0] dat;
      logic [SW-1:0] sel;
      logic          we;
      logic          cyc;
      logic          stb;
   } wb_req_t;

   typedef struct packed {
      logic [DW-1:0] dat;
      logic          ack;
   } wb_rsp_t;

   typedef struct packed {
      logic              stb;
      logic [SET_AW-1:0] addr;
      logic [SET_DW-1:0] data;
   } set_bus_t;

endpackage

`default_nettype wire

//--- source/vita_time.sv
`timescale 1ns/1ps
`default_nettype none

module vita_time
  (
   input  wire                 wb_clk,
   input  wire                 wb_rst,
   input  u1e_pkg::set_bus_t   set_i,
   input  wire                 pps_i,
   output logic [63:0]         vita_time_o,
   output logic                pps_int_o
   );

   logic [u1e_pkg::SET_AW-1:0] reg_offs;
   logic                       wr_hi;
   logic                       wr_lo;
   logic                       wr_ctrl;

   logic [31:0]                pend_secs;
   logic [31:0]                pend_ticks;
   logic                       mode_pps;
   logic                       armed;

   logic [1:0]                 pps_sync;
   logic                       pps_dly;
   logic                       pps_edge;

   logic [31:0]                secs;
   logic [31:0]                ticks;

   ////////////////////
   // Settings decode
   assign reg_offs = set_i.addr - u1e_pkg::SR_TIME_BASE;
   assign wr_hi    = set_i.stb & (reg_offs == u1e_pkg::SR_TIME_HI);
   assign wr_lo    = set_i.stb & (reg_offs == u1e_pkg::SR_TIME_LO);
   assign wr_ctrl  = set_i.stb & (reg_offs == u1e_pkg::SR_TIME_CTRL);

   always_ff @(posedge wb_clk)
   begin
      if (wr_hi)
         pend_secs <= set_i.data;
      if (wr_lo)
         pend_ticks <= set_i.data;
   end

   ////////////////////
   // PPS sync and edge
   assign pps_edge = pps_sync[1] & ~pps_dly;

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
      begin
         pps_sync  <= 2'b00;
         pps_dly   <= 1'b0;
         pps_int_o <= 1'b0;
         mode_pps  <= 1'b0;
         armed     <= 1'b0;
      end
      else
      begin
         pps_sync  <= {pps_sync[0], pps_i};
         pps_dly   <= pps_sync[1];
         pps_int_o <= pps_edge;
         if (wr_ctrl)
            mode_pps <= set_i.data[0];
         if (wr_lo && mode_pps)
            armed <= 1'b1;                 // Wait for the next second
         else if (pps_edge)
            armed <= 1'b0;
      end
   end

   ////////////////////
   // Time counter
   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
      begin
         secs  <= '0;
         ticks <= '0;
      end
      else if (wr_lo && !mode_pps)
      begin
         secs  <= pend_secs;
         ticks <= set_i.data;
      end
      else if (pps_edge && armed)
      begin
         secs  <= pend_secs;
         ticks <= pend_ticks;
      end
      else if (ticks == u1e_pkg::TICKS_PER_SEC - 32'd1)
      begin
         secs  <= secs + 32'd1;
         ticks <= '0;
      end
      else
      begin
         ticks <= ticks + 32'd1;
      end
   end

   assign vita_time_o = {secs, ticks};

endmodule

`default_nettype wire

//--- source/wb_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module wb_decoder
  (
   input  wire                 wb_clk,
   input  u1e_pkg::wb_req_t    m_req_i,
   output u1e_pkg::wb_rsp_t    m_rsp_o,

   output u1e_pkg::wb_req_t    misc_req_o,
   input  u1e_pkg::wb_rsp_t    misc_rsp_i,

   output u1e_pkg::wb_req_t    set_req_o,
   input  u1e_pkg::wb_rsp_t    set_rsp_i
   );

   logic [u1e_pkg::DECODE_W-1:0] slot;
   logic                         hit_misc;
   logic                         hit_set;
   logic                         m_act;

   // Upper address bits select the slave
   assign slot     = m_req_i.adr[u1e_pkg::AW-1 -: u1e_pkg::DECODE_W];
   assign hit_misc = (slot == u1e_pkg::SLOT_MISC);
   assign hit_set  = (slot == u1e_pkg::SLOT_SETTINGS);
   assign m_act    = m_req_i.cyc & m_req_i.stb;

   ////////////////////
   // Request fan-out
   always_comb
   begin
      misc_req_o     = m_req_i;
      misc_req_o.cyc = m_req_i.cyc & hit_misc;
      misc_req_o.stb = m_req_i.stb & hit_misc;

      set_req_o      = m_req_i;
      set_req_o.cyc  = m_req_i.cyc & hit_set;
      set_req_o.stb  = m_req_i.stb & hit_set;
   end

   ////////////////////
   // Response mux
   always_comb
   begin
      if (hit_misc)
      begin
         m_rsp_o = misc_rsp_i;
      end
      else if (hit_set)
      begin
         m_rsp_o = set_rsp_i;
      end
      else
      begin
         // Nothing lives here, answer so the host never hangs
         m_rsp_o.dat = '0;
         m_rsp_o.ack = m_act;
      end
   end

endmodule

`default_nettype wire

//--- test/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen
  (
   output logic clk_o,
   output logic rst_o
   );

   // 100 MHz bus clock
   initial
   begin
      clk_o = 1'b0;
      forever
         #5 clk_o = ~clk_o;
   end

   initial
   begin
      rst_o = 1'b1;
      repeat (8) @(posedge clk_o);   // Held over the first 8 edges
      #1;
      rst_o = 1'b0;
   end

endmodule

`default_nettype wire

//--- test/u1e_core_properties.sv
`timescale 1ns/1ps
`default_nettype none

module u1e_core_properties
  (
   input wire                 wb_clk,
   input wire                 wb_rst,
   input u1e_pkg::wb_req_t    m_req_i,
   input u1e_pkg::wb_rsp_t    m_rsp_i,
   input u1e_pkg::set_bus_t   set_i,
   input wire                 pps_int_i,
   input wire [63:0]          vita_time_i
   );

   // Zero wait states, but never an unsolicited ack
   a_ack_needs_stb : assert property (@(posedge wb_clk) disable iff (wb_rst)
      m_rsp_i.ack |-> (m_req_i.cyc && m_req_i.stb))
      else $error("ack seen without cyc and stb");

   a_set_stb_single : assert property (@(posedge wb_clk) disable iff (wb_rst)
      set_i.stb |=> !set_i.stb)
      else $error("settings strobe held for two cycles");

   a_pps_int_single : assert property (@(posedge wb_clk) disable iff (wb_rst)
      pps_int_i |=> !pps_int_i)
      else $error("pps_int_o held for two cycles");

   a_ticks_in_range : assert property (@(posedge wb_clk) disable iff (wb_rst)
      vita_time_i[31:0] < u1e_pkg::TICKS_PER_SEC)
      else $error("tick field reached TICKS_PER_SEC");

endmodule

bind u1e_core u1e_core_properties u_props
  (.wb_clk(wb_clk), .wb_rst(wb_rst),
   .m_req_i(m_req_i), .m_rsp_i(m_rsp_o),
   .set_i(set_bus), .pps_int_i(pps_int_o), .vita_time_i(vita_time_o));

`default_nettype wire

//--- test/u1e_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module u1e_core_tb;

   typedef enum logic [2:0] {OP_WR, OP_RD, OP_PINRD, OP_PINS, OP_LOAD, OP_PPS} op_e;

   // Timer rows carry seconds in dat and ticks in exp
   typedef struct packed {
      op_e         op;
      logic [10:0] adr;
      logic [31:0] dat;
      logic [31:0] exp;
   } step_t;

   wire               wb_clk;
   wire               wb_rst;
   u1e_pkg::wb_req_t  m_req;
   u1e_pkg::wb_rsp_t  m_rsp;
   logic [7:0]        dip_sw;
   logic [2:0]        debug_pb;
   logic [2:0]        cgen_st;      // Status, lock detect, ref monitor
   logic              pps;
   wire  [2:0]        debug_led;
   wire  [3:0]        ctl_pins;     // sync_b, ref_sel, rx_overrun, tx_underrun
   wire  [63:0]       vita_time;
   wire               pps_int;
   logic [31:0]       lfsr_state;
   int                cyc_cnt = 0;
   step_t             steps [23];
   logic [15:0]       rd;

   tb_clock_gen u_clk_gen (.clk_o(wb_clk), .rst_o(wb_rst));

   u1e_core DUT
     (.wb_clk(wb_clk), .wb_rst(wb_rst),
      .m_req_i(m_req), .m_rsp_o(m_rsp),
      .dip_sw_i(dip_sw), .debug_pb_i(debug_pb),
      .cgen_st_status_i(cgen_st[2]), .cgen_st_ld_i(cgen_st[1]),
      .cgen_st_refmon_i(cgen_st[0]),
      .debug_led_o(debug_led),
      .cgen_sync_b_o(ctl_pins[3]), .cgen_ref_sel_o(ctl_pins[2]),
      .rx_overrun_o(ctl_pins[1]), .tx_underrun_o(ctl_pins[0]),
      .pps_i(pps), .vita_time_o(vita_time), .pps_int_o(pps_int));

   always @(posedge wb_clk)
      cyc_cnt <= cyc_cnt + 1;

   task automatic abort_run();
      $display("test failed");
      $fatal(1, "Stopped at the first error");
   endtask

   task automatic check_equal(input string name, input logic [63:0] got,
                              input logic [63:0] want);
      assert (got === want)
      else
      begin
         $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, want);
         abort_run();
      end
   endtask

   ////////////////////
   // Stimulus sources
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   task automatic take_bits(input int n, output logic [7:0] bits);
      bits = '0;
      for (int i = 0; i < n; i++)
      begin
         bits = {bits[6:0], lfsr_state[0]};   // One step per bit
         lfsr_state = lfsr_next(lfsr_state);
      end
   endtask

   task automatic randomize_pins();
      logic [7:0] bits;
      take_bits(8, bits);
      dip_sw = bits;
      take_bits(3, bits);
      debug_pb = bits[2:0];
      take_bits(3, bits);
      cgen_st = bits[2:0];
   endtask

   // Packing of the read-only misc registers
   function automatic logic [15:0] expected_pins(input logic [6:0] offs);
      if (offs == u1e_pkg::MR_CGEN_ST)
         return {13'd0, cgen_st};
      return {5'd0, debug_pb, dip_sw};
   endfunction

   // Reference count of seconds and ticks
   function automatic logic [63:0] advance(input logic [63:0] t, input int n);
      logic [31:0] secs;
      logic [31:0] ticks;
      secs  = t[63:32];
      ticks = t[31:0];
      for (int i = 0; i < n; i++)
      begin
         if (ticks == u1e_pkg::TICKS_PER_SEC - 32'd1)
         begin
            secs  = secs + 32'd1;
            ticks = '0;
         end
         else
            ticks = ticks + 32'd1;
      end
      return {secs, ticks};
   endfunction

   ////////////////////
   // Bus host
   task automatic bus_xfer(input logic we, input logic [10:0] adr,
                           input logic [15:0] wdat, output logic [15:0] rdat);
      int waited;
      @(posedge wb_clk);
      #1;
      m_req = '{adr: adr, dat: wdat, sel: 2'b11, we: we, cyc: 1'b1, stb: 1'b1};
      waited = 0;
      @(negedge wb_clk);
      while (!m_rsp.ack && waited < 16)
      begin
         @(negedge wb_clk);
         waited++;
      end
      if (!m_rsp.ack)
      begin
         $display("Bus timeout, no ack at address 0x%h", adr);
         abort_run();
      end
      rdat = m_rsp.dat;
      @(posedge wb_clk);
      #1;
      m_req = '0;           // Strobe dropped after the ack
   endtask

   // The high half follows the low half and fires the strobe
   task automatic write32(input logic [7:0] rnum, input logic [31:0] val);
      logic [10:0] adr;
      logic [15:0] unused_rd;
      adr = {u1e_pkg::SLOT_SETTINGS, rnum[4:0], 2'b00};
      bus_xfer(1'b1, adr, val[15:0], unused_rd);
      bus_xfer(1'b1, adr | 11'h002, val[31:16], unused_rd);
   endtask

   ////////////////////
   // Timer sequences
   task automatic load_now(input logic [31:0] s, input logic [31:0] t);
      write32(u1e_pkg::SR_TIME_BASE + u1e_pkg::SR_TIME_CTRL, 32'd0);
      write32(u1e_pkg::SR_TIME_BASE + u1e_pkg::SR_TIME_HI, s);
      write32(u1e_pkg::SR_TIME_BASE + u1e_pkg::SR_TIME_LO, t);
      @(posedge wb_clk);
      #1;
      check_equal("vita_time_o", vita_time, {s, t});
      repeat (u1e_pkg::TICKS_PER_SEC - t) @(posedge wb_clk);
      #1;
      check_equal("vita_time_o", vita_time, {s + 32'd1, 32'd0});
   endtask

   task automatic pulse_pps(input logic load_armed, input logic [63:0] loaded);
      logic [63:0] v0;
      logic [63:0] want;
      v0  = vita_time;
      pps = 1'b1;
      for (int k = 1; k <= 3; k++)
      begin
         @(posedge wb_clk);
         #1;
         want = (load_armed && k == 3) ? loaded : advance(v0, k);
         check_equal("pps_int_o", {63'd0, pps_int}, {63'd0, k == 3});
         check_equal("vita_time_o", vita_time, want);
      end
      @(posedge wb_clk);
      #1;
      check_equal("pps_int_o", {63'd0, pps_int}, 64'd0);
      pps = 1'b0;
      repeat (4) @(posedge wb_clk);   // Let the synchronizer settle low
      #1;
   endtask

   task automatic load_on_pps(input logic [31:0] s, input logic [31:0] t);
      logic [63:0] v0;
      int          c0;
      write32(u1e_pkg::SR_TIME_BASE + u1e_pkg::SR_TIME_CTRL, 32'd1);
      v0 = vita_time;
      c0 = cyc_cnt;
      write32(u1e_pkg::SR_TIME_BASE + u1e_pkg::SR_TIME_HI, s);
      write32(u1e_pkg::SR_TIME_BASE + u1e_pkg::SR_TIME_LO, t);
      @(posedge wb_clk);
      #1;
      // Only armed so the old count runs on
      check_equal("vita_time_o", vita_time, advance(v0, cyc_cnt - c0));
      pulse_pps(1'b1, {s, t});
      pulse_pps(1'b0, 64'd0);
   endtask

   initial
   begin
      m_req      = '0;
      dip_sw     = '0;
      debug_pb   = '0;
      cgen_st    = '0;
      pps        = 1'b0;
      lfsr_state = 32'h6409_bcae;
      steps = '{
         '{OP_RD,    11'h000, 32'h0,      32'h0000},   // Reset values
         '{OP_RD,    11'h008, 32'h0,      32'h0000},
         '{OP_RD,    11'h004, 32'h0,      32'h0003},
         '{OP_PINS,  11'h000, 32'h0,      32'h000C},
         '{OP_WR,    11'h000, 32'h0005,   32'h0},
         '{OP_RD,    11'h000, 32'h0,      32'h0005},
         '{OP_WR,    11'h004, 32'h0001,   32'h0},
         '{OP_RD,    11'h004, 32'h0,      32'h0001},
         '{OP_WR,    11'h008, 32'hA5A2,   32'h0},
         '{OP_RD,    11'h008, 32'h0,      32'hA5A2},
         '{OP_PINS,  11'h000, 32'h0,      32'h0066},
         '{OP_WR,    11'h000, 32'h0002,   32'h0},      // LED bits 0 and 1 swap on the pins
         '{OP_WR,    11'h004, 32'h0002,   32'h0},
         '{OP_WR,    11'h008, 32'h0001,   32'h0},
         '{OP_PINS,  11'h000, 32'h0,      32'h0019},
         '{OP_PINRD, 11'h002, 32'h0,      32'h0},
         '{OP_PINRD, 11'h006, 32'h0,      32'h0},
         '{OP_RD,    11'h00A, 32'h0,      32'hBEEF},
         '{OP_RD,    11'h100, 32'h0,      32'h0000},   // Unmapped slots
         '{OP_RD,    11'h780, 32'h0,      32'h0000},
         '{OP_RD,    11'h280, 32'h0,      32'h0000},   // Slot 5 reads as zero
         '{OP_LOAD,  11'h000, 32'h1234,   32'd90},
         '{OP_PPS,   11'h000, 32'h5000,   32'd7}
      };
      repeat (9) @(posedge wb_clk);
      #1;
      foreach (steps[i])
      begin
         case (steps[i].op)
            OP_WR   : bus_xfer(1'b1, steps[i].adr, steps[i].dat[15:0], rd);
            OP_RD   :
            begin
               bus_xfer(1'b0, steps[i].adr, 16'h0, rd);
               check_equal("m_rsp_o.dat", {48'd0, rd}, {48'd0, steps[i].exp[15:0]});
            end
            OP_PINRD:
            begin
               randomize_pins();
               bus_xfer(1'b0, steps[i].adr, 16'h0, rd);
               check_equal("m_rsp_o.dat", {48'd0, rd},
                           {48'd0, expected_pins(steps[i].adr[6:0])});
            end
            OP_PINS : check_equal("{debug_led_o, cgen and test pins}",
                                  {57'd0, debug_led, ctl_pins}, {57'd0, steps[i].exp[6:0]});
            OP_LOAD : load_now(steps[i].dat, steps[i].exp);
            OP_PPS  : load_on_pps(steps[i].dat, steps[i].exp);
            default : ;
         endcase
      end
      $display("test passed");
      $finish;
   end

endmodule

`default_nettype wire
